// ==== rtl/mac_pkg.sv ====
// multiple access controller types
package mac_pkg;

  // ---------------------------------------------------------------------
  // size codes, used for transfer size and bus width
  // ---------------------------------------------------------------------
  typedef logic [1:0] size_t;

  localparam size_t SIZE_8    = 2'd0;
  localparam size_t SIZE_16   = 2'd1;
  localparam size_t SIZE_32   = 2'd2;
  localparam size_t SIZE_RSVD = 2'd3;  // not a legal bus width

  typedef logic [1:0]  acc_cnt_t;      // accesses still to run, minus one
  typedef logic [31:0] word_t;
  typedef logic [1:0]  wait_t;         // extra cycles per access

  // ---------------------------------------------------------------------
  // grouped ports
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic  valid;                      // single cycle, only while not busy
    logic  write;
    size_t size;
    word_t wdata;
  } host_req_t;

  typedef struct packed {
    logic     cs;
    logic     we;
    acc_cnt_t access_num;              // counts down to 0
    word_t    wdata;                   // slice in the low lanes
  } mem_bus_t;

  // sequencer states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,                  // first cycle of an access
    ST_WAIT   = 2'd2                   // wait-state cycles
  } mac_state_e;

  // apb register map
  localparam int unsigned REG_BUS_WIDTH = 32'h0;
  localparam int unsigned REG_WAIT      = 32'h4;

endpackage

// ==== rtl/mac_config_regs.sv ====
// configuration register block
`timescale 1ns/1ps

module mac_config_regs
  import mac_pkg::*;
#(
  parameter int APB_ADDR_W = 8
)(
  input  logic                  sys_clk2,
  input  logic                  n_sys_reset2,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  word_t                 pwdata,
  output word_t                 prdata,
  output logic                  pready,
  output size_t                 bus_width,
  output wait_t                 wait_states
);

  logic apb_wr;     // access phase of a write
  logic sel_width;
  logic sel_wait;

  assign apb_wr    = psel && penable && pwrite;
  assign sel_width = (paddr == APB_ADDR_W'(REG_BUS_WIDTH));
  assign sel_wait  = (paddr == APB_ADDR_W'(REG_WAIT));

  assign pready = 1'b1;  // always zero wait states on apb

  // ---------------------------------------------------------------------
  // register writes
  // ---------------------------------------------------------------------
  always_ff @(posedge sys_clk2 or negedge n_sys_reset2)
  begin
    if (!n_sys_reset2)
    begin
      bus_width   <= SIZE_8;   // 8 bit bus out of reset
      wait_states <= '0;
    end
    else if (apb_wr)
    begin
      // reserved width code leaves the old width in place
      if (sel_width && (size_t'(pwdata[1:0]) != SIZE_RSVD))
        bus_width <= size_t'(pwdata[1:0]);
      if (sel_wait)
        wait_states <= wait_t'(pwdata[1:0]);
    end
  end

  // ---------------------------------------------------------------------
  // read mux
  // ---------------------------------------------------------------------
  always_comb
  begin
    if (sel_width)
      prdata = word_t'(bus_width);
    else if (sel_wait)
      prdata = word_t'(wait_states);
    else
      prdata = '0;              // unmapped
  end

  // enable phase always follows a setup phase of the same transfer
  a_apb_enable: assert property (
    @(posedge sys_clk2) disable iff (!n_sys_reset2)
    penable |-> psel && $past(psel)
  );

endmodule

// ==== rtl/mac_access_seq.sv ====
// access sequencer
`timescale 1ns/1ps

module mac_access_seq
  import mac_pkg::*;
(
  input  logic      sys_clk2,
  input  logic      n_sys_reset2,
  input  host_req_t host_req,
  input  size_t     bus_width,
  input  wait_t     wait_states,
  output logic      busy,
  output logic      done,
  output logic      latch,
  output acc_cnt_t  access_num,
  output size_t     r_xfer_size,
  output size_t     r_bus_size,
  output logic      mem_cs,
  output logic      mem_we
);

  mac_state_e state;
  wait_t      wait_cnt;    // wait cycles left in current access
  logic       r_write;
  logic       accept;
  acc_cnt_t   first_num;   // n-1 for the request on the port

  assign accept = host_req.valid && (state == ST_IDLE);  // valid while busy is dropped

  // ---------------------------------------------------------------------
  // accesses needed: transfer width over bus width, at least one
  // ---------------------------------------------------------------------
  always_comb
  begin
    first_num = '0;        // transfer fits in one access
    if ((host_req.size == SIZE_32) && (bus_width == SIZE_8))
      first_num = 2'd3;
    else if (((host_req.size == SIZE_32) && (bus_width == SIZE_16)) ||
             ((host_req.size == SIZE_16) && (bus_width == SIZE_8)))
      first_num = 2'd1;
  end

  // last cycle of an access, 1+W cycles after it starts
  assign latch = ((state == ST_ACCESS) && (wait_states == '0)) ||
                 ((state == ST_WAIT) && (wait_cnt == '0));

  assign done   = latch && (access_num == '0);
  assign busy   = (state != ST_IDLE);
  assign mem_cs = (state != ST_IDLE);  // no gap between accesses
  assign mem_we = mem_cs && r_write;

  // ---------------------------------------------------------------------
  // fsm and counters
  // ---------------------------------------------------------------------
  always_ff @(posedge sys_clk2 or negedge n_sys_reset2)
  begin
    if (!n_sys_reset2)
    begin
      state       <= ST_IDLE;
      wait_cnt    <= '0;
      access_num  <= '0;
      r_xfer_size <= SIZE_8;
      r_bus_size  <= SIZE_8;
      r_write     <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (accept)
          begin
            state       <= ST_ACCESS;
            access_num  <= first_num;
            r_xfer_size <= host_req.size;
            r_bus_size  <= bus_width;   // width held for whole transfer
            r_write     <= host_req.write;
          end
        ST_ACCESS:
          if (!latch)
          begin
            state    <= ST_WAIT;
            wait_cnt <= wait_states - 1'b1;
          end
        ST_WAIT:
          if (!latch)
            wait_cnt <= wait_cnt - 1'b1;
        default:
          state <= ST_IDLE;
      endcase

      // end of an access, next slice or finish
      if (latch)
      begin
        if (access_num == '0)
          state <= ST_IDLE;
        else
        begin
          access_num <= access_num - 1'b1;
          state      <= ST_ACCESS;
        end
      end
    end
  end

  // counter holds at 0 through the last access, never wraps
  a_no_underflow: assert property (
    @(posedge sys_clk2) disable iff (!n_sys_reset2)
    (state != ST_IDLE) && (access_num == '0) |=> (access_num == '0)
  );

  // cs drops in the cycle after the final access
  a_cs_release: assert property (
    @(posedge sys_clk2) disable iff (!n_sys_reset2)
    done |=> !mem_cs
  );

endmodule

// ==== rtl/mac_read_assemble.sv ====
// read data assembly
`timescale 1ns/1ps

module mac_read_assemble
  import mac_pkg::*;
(
  input  logic     sys_clk2,
  input  logic     n_sys_reset2,
  input  logic     latch,
  input  acc_cnt_t access_num,
  input  size_t    r_xfer_size,
  input  size_t    r_bus_size,
  input  word_t    mem_rdata,
  output word_t    host_rdata
);

  word_t r_data;     // slots of earlier accesses
  word_t assembled;  // stored slots plus live final slice

  // ---------------------------------------------------------------------
  // store slices of all accesses but the last
  // ---------------------------------------------------------------------
  always_ff @(posedge sys_clk2 or negedge n_sys_reset2)
  begin
    if (!n_sys_reset2)
      r_data <= '0;
    else if (latch && (access_num != '0))
    begin
      case (r_bus_size)
        SIZE_8:
          r_data[{access_num, 3'b000} +: 8] <= mem_rdata[7:0];
        SIZE_16:
          r_data[{access_num[0], 4'b0000} +: 16] <= mem_rdata[15:0];
        default:
          r_data <= mem_rdata;  // 32 bit bus, single access anyway
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // slot 0 comes straight from the bus
  // ---------------------------------------------------------------------
  always_comb
  begin
    case (r_bus_size)
      SIZE_8:
        assembled = {r_data[31:8], mem_rdata[7:0]};
      SIZE_16:
        assembled = {r_data[31:16], mem_rdata[15:0]};
      default:
        assembled = mem_rdata;
    endcase
  end

  // replicate narrow transfers across the host word
  always_comb
  begin
    case (r_xfer_size)
      SIZE_8:
        host_rdata = {4{assembled[7:0]}};
      SIZE_16:
        host_rdata = {2{assembled[15:0]}};
      default:
        host_rdata = assembled;   // full word
    endcase
  end

endmodule

// ==== rtl/mac_write_steer.sv ====
// write data steering
`timescale 1ns/1ps

module mac_write_steer
  import mac_pkg::*;
(
  input  word_t    wdata,
  input  acc_cnt_t access_num,
  input  size_t    r_xfer_size,
  input  size_t    r_bus_size,
  output word_t    mem_wdata
);

  word_t bus_slice;  // slice k of the word, zero extended
  word_t xfer_mask;  // trims transfers narrower than the bus

  always_comb
  begin
    case (r_bus_size)
      SIZE_8:
        bus_slice = {24'h0, wdata[{access_num, 3'b000} +: 8]};
      SIZE_16:
        bus_slice = {16'h0, wdata[{access_num[0], 4'b0000} +: 16]};
      default:
        bus_slice = wdata;
    endcase
  end

  always_comb
  begin
    case (r_xfer_size)
      SIZE_8:  xfer_mask = 32'h0000_00ff;
      SIZE_16: xfer_mask = 32'h0000_ffff;
      default: xfer_mask = '1;
    endcase
  end

  assign mem_wdata = bus_slice & xfer_mask;  // no effect once slice <= transfer

endmodule

// ==== rtl/mac_top.sv ====
// multiple access controller top
`timescale 1ns/1ps

module mac_top
  import mac_pkg::*;
#(
  parameter int APB_ADDR_W = 8
)(
  input  logic                  sys_clk2,
  input  logic                  n_sys_reset2,
  // apb
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  word_t                 pwdata,
  output word_t                 prdata,
  output logic                  pready,
  // host
  input  host_req_t             host_req,
  output word_t                 host_rdata,
  output logic                  done,
  output logic                  busy,
  // memory
  output mem_bus_t              mem_bus,
  input  word_t                 mem_rdata
);

  size_t    bus_width;
  wait_t    wait_states;
  logic     latch;
  acc_cnt_t access_num;
  size_t    r_xfer_size;
  size_t    r_bus_size;
  logic     mem_cs;
  logic     mem_we;
  word_t    r_wdata;     // host write word, held over all accesses
  word_t    mem_wdata;

  // host drives wdata only with valid
  always_ff @(posedge sys_clk2)
  begin
    if (host_req.valid && host_req.write && !busy)
      r_wdata <= host_req.wdata;
  end

  // ---------------------------------------------------------------------
  // instances
  // ---------------------------------------------------------------------
  mac_config_regs #(
    .APB_ADDR_W (APB_ADDR_W)
  ) u_regs (
    .sys_clk2     (sys_clk2),
    .n_sys_reset2 (n_sys_reset2),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .bus_width    (bus_width),
    .wait_states  (wait_states)
  );

  mac_access_seq u_seq (
    .sys_clk2     (sys_clk2),
    .n_sys_reset2 (n_sys_reset2),
    .host_req     (host_req),
    .bus_width    (bus_width),
    .wait_states  (wait_states),
    .busy         (busy),
    .done         (done),
    .latch        (latch),
    .access_num   (access_num),
    .r_xfer_size  (r_xfer_size),
    .r_bus_size   (r_bus_size),
    .mem_cs       (mem_cs),
    .mem_we       (mem_we)
  );

  mac_read_assemble u_rd (
    .sys_clk2     (sys_clk2),
    .n_sys_reset2 (n_sys_reset2),
    .latch        (latch),
    .access_num   (access_num),
    .r_xfer_size  (r_xfer_size),
    .r_bus_size   (r_bus_size),
    .mem_rdata    (mem_rdata),
    .host_rdata   (host_rdata)
  );

  mac_write_steer u_wr (
    .wdata        (r_wdata),
    .access_num   (access_num),
    .r_xfer_size  (r_xfer_size),
    .r_bus_size   (r_bus_size),
    .mem_wdata    (mem_wdata)
  );

  // external bus
  assign mem_bus = '{cs: mem_cs, we: mem_we, access_num: access_num, wdata: mem_wdata};

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
)(
  output logic sys_clk2,
  output logic n_sys_reset2
);

  initial
  begin
    sys_clk2 = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk2 = ~sys_clk2;
  end

  // reset low for the first few edges, released on a rising edge
  initial
  begin
    n_sys_reset2 = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk2);
    n_sys_reset2 <= 1'b1;
  end

endmodule

// ==== tests/tb_mac_top.sv ====
// mac directed testbench
`timescale 1ns/1ps

module tb_mac_top
  import mac_pkg::*;
();

  localparam int             TIMEOUT    = 200;  // cycles per wait loop
  localparam logic [7:0]     ADDR_WIDTH = 8'(REG_BUS_WIDTH);
  localparam logic [7:0]     ADDR_WAIT  = 8'(REG_WAIT);

  logic      sys_clk2;
  logic      n_sys_reset2;
  logic      psel;
  logic      penable;
  logic      pwrite;
  logic [7:0] paddr;
  word_t     pwdata;
  word_t     prdata;
  logic      pready;
  host_req_t host_req;
  word_t     host_rdata;
  logic      done;
  logic      busy;
  mem_bus_t  mem_bus;
  word_t     mem_rdata;

  size_t     cur_width = SIZE_8;   // config as last written
  wait_t     cur_wait = '0;
  word_t     rd_word = '0;         // memory content for the next read
  int        cs_run = 0;           // cycles into the current access
  mem_bus_t  bus_log[$];           // bus state at the end of each access
  int        errors = 0;
  int        test_base = 0;
  int        tests_run = 0;
  int        tests_failed = 0;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) u_clk (
    .sys_clk2     (sys_clk2),
    .n_sys_reset2 (n_sys_reset2)
  );

  mac_top #(.APB_ADDR_W(8)) uut (
    .sys_clk2 (sys_clk2), .n_sys_reset2 (n_sys_reset2),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .host_req (host_req), .host_rdata (host_rdata), .done (done), .busy (busy),
    .mem_bus (mem_bus), .mem_rdata (mem_rdata)
  );

  // ---------------------------------------------------------------------
  // memory model
  // ---------------------------------------------------------------------
  always_comb
  begin
    case (cur_width)  // slice k of rd_word on the low lanes, filler above
      SIZE_8:  mem_rdata = {24'ha5a5a5, rd_word[8 * int'(mem_bus.access_num) +: 8]};
      SIZE_16: mem_rdata = {16'h5a5a, rd_word[16 * int'(mem_bus.access_num) +: 16]};
      default: mem_rdata = rd_word;
    endcase
  end

  // last cycle of an access is cycle W of each cs run
  always @(posedge sys_clk2)
  begin
    if (mem_bus.cs)
    begin
      if (cs_run == int'(cur_wait))
      begin
        bus_log.push_back(mem_bus);
        cs_run = 0;
      end
      else
        cs_run = cs_run + 1;
    end
    else
      cs_run = 0;
  end

  // ---------------------------------------------------------------------
  // expected values
  // ---------------------------------------------------------------------
  function automatic int num_accesses(input size_t xfer, input size_t bus);
    if (xfer > bus)
      return 1 << (xfer - bus);
    return 1;  // fits in one access
  endfunction

  function automatic word_t low_bits(input word_t d, input int w);
    return d & word_t'((64'd1 << w) - 64'd1);
  endfunction

  function automatic word_t exp_wslice(input word_t d, input size_t xfer, input size_t bus,
                                       input int k);
    int bw;
    bw = 8 << bus;
    if (xfer < bus)
      return low_bits(d, 8 << xfer);  // narrow transfer, zero extended
    return low_bits(d >> (k * bw), bw);
  endfunction

  // transfer-width value repeated up to 32 bits
  function automatic word_t exp_read(input word_t m, input size_t xfer);
    int    w;
    word_t r;
    w = 8 << xfer;
    r = '0;
    for (int i = 0; i < 32; i += w)
      r = r | (low_bits(m, w) << i);
    return r;
  endfunction

  // ---------------------------------------------------------------------
  // bus tasks
  // ---------------------------------------------------------------------
  task automatic note_error(input string what, input word_t got, input word_t exp);
    $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_base)
      $display("test %-14s ok", name);
    else
    begin
      tests_failed++;
      $display("test %-14s %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  task automatic apb_write(input logic [7:0] addr, input word_t data);
    @(posedge sys_clk2);
    psel    <= 1'b1;   // setup phase
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge sys_clk2);
    penable <= 1'b1;   // access phase
    @(posedge sys_clk2);
    if (!pready)
      note_error("pready on write", 32'(pready), 32'd1);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output word_t data);
    @(posedge sys_clk2);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge sys_clk2);
    penable <= 1'b1;
    @(posedge sys_clk2);
    data    = prdata;  // value of the access cycle
    if (!pready)
      note_error("pready on read", 32'(pready), 32'd1);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_config(input size_t width, input wait_t ws);
    apb_write(ADDR_WIDTH, word_t'(width));
    apb_write(ADDR_WAIT, word_t'(ws));
    cur_width = width;
    cur_wait  = ws;
  endtask

  // one host transfer, checked for timing, bus slices and read result
  task automatic run_xfer(input logic write, input size_t size, input word_t wdata,
                          input logic inject);
    int    cnt;
    int    n;
    logic  got_done;
    word_t rdata;
    n        = num_accesses(size, cur_width);
    cnt      = 0;
    got_done = 1'b0;
    rdata    = '0;
    rd_word  = $urandom();
    bus_log.delete();
    @(posedge sys_clk2);
    host_req <= '{valid: 1'b1, write: write, size: size, wdata: wdata};
    @(posedge sys_clk2);  // accepting edge
    if (busy)
      note_error("busy before accept", 32'(busy), 32'd0);
    host_req.valid <= 1'b0;
    while (!got_done && cnt < TIMEOUT)
    begin
      @(posedge sys_clk2);
      cnt++;
      if (done)
      begin
        got_done = 1'b1;
        rdata    = host_rdata;  // valid with done
      end
      else if (!busy)
        note_error("busy dropped before done", 32'(busy), 32'd1);
      if (inject && cnt == 2 && !got_done)  // request while busy
        host_req <= '{valid: 1'b1, write: 1'b1, size: SIZE_8, wdata: 32'hffff_ffff};
      else
        host_req.valid <= 1'b0;
    end
    if (!got_done)
    begin
      $display("timeout: done did not arrive within %0d cycles", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
    if (cnt != n * (1 + int'(cur_wait)))
      note_error("cycles to done", word_t'(cnt), word_t'(n * (1 + int'(cur_wait))));
    @(posedge sys_clk2);
    if (busy)
      note_error("busy after done", 32'(busy), 32'd0);
    if (done)
      note_error("done longer than one cycle", 32'(done), 32'd0);
    if (bus_log.size() != n)
      note_error("number of accesses", word_t'(bus_log.size()), word_t'(n));
    for (int i = 0; i < bus_log.size() && i < n; i++)
    begin
      if (int'(bus_log[i].access_num) != n - 1 - i)
        note_error("access_num order", word_t'(bus_log[i].access_num), word_t'(n - 1 - i));
      if (bus_log[i].we != write)
        note_error("write enable", 32'(bus_log[i].we), 32'(write));
      if (write && bus_log[i].wdata != exp_wslice(wdata, size, cur_width, n - 1 - i))
        note_error("write slice", bus_log[i].wdata,
                   exp_wslice(wdata, size, cur_width, n - 1 - i));
    end
    if (!write && rdata != exp_read(rd_word, size))
      note_error("read data", rdata, exp_read(rd_word, size));
  endtask

  // ---------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------
  task automatic test_regs();
    word_t v;
    if (busy || done || mem_bus.cs)
      note_error("busy/done/cs after reset", {29'd0, busy, done, mem_bus.cs}, 32'd0);
    apb_read(ADDR_WIDTH, v);
    if (v != 32'd0)
      note_error("width after reset", v, 32'd0);
    apb_read(ADDR_WAIT, v);
    if (v != 32'd0)
      note_error("wait after reset", v, 32'd0);
    apb_write(ADDR_WIDTH, 32'd1);
    apb_read(ADDR_WIDTH, v);
    if (v != 32'd1)
      note_error("width readback", v, 32'd1);
    apb_write(ADDR_WAIT, 32'd2);
    apb_read(ADDR_WAIT, v);
    if (v != 32'd2)
      note_error("wait readback", v, 32'd2);
    apb_write(ADDR_WIDTH, 32'd3);  // reserved code, old width stays
    apb_read(ADDR_WIDTH, v);
    if (v != 32'd1)
      note_error("reserved width", v, 32'd1);
    apb_read(8'h08, v);
    if (v != 32'd0)
      note_error("unused address", v, 32'd0);
    end_test("registers");
  endtask

  task automatic test_wide_writes();
    set_config(SIZE_8, 2'd0);
    run_xfer(1'b1, SIZE_32, $urandom(), 1'b0);  // four bytes, msb first
    set_config(SIZE_16, 2'd0);
    run_xfer(1'b1, SIZE_32, $urandom(), 1'b0);
    end_test("wide writes");
  endtask

  task automatic test_wide_reads();
    set_config(SIZE_8, 2'd0);
    run_xfer(1'b0, SIZE_32, '0, 1'b0);
    set_config(SIZE_16, 2'd0);
    run_xfer(1'b0, SIZE_32, '0, 1'b0);
    set_config(SIZE_32, 2'd0);
    run_xfer(1'b0, SIZE_32, '0, 1'b0);
    end_test("wide reads");
  endtask

  task automatic test_narrow_reads();
    set_config(SIZE_32, 2'd0);
    run_xfer(1'b0, SIZE_8, '0, 1'b0);   // byte four times
    set_config(SIZE_8, 2'd0);
    run_xfer(1'b0, SIZE_16, '0, 1'b0);  // halfword twice
    end_test("narrow reads");
  endtask

  task automatic test_wait_timing();
    set_config(SIZE_8, 2'd0);
    run_xfer(1'b0, SIZE_32, '0, 1'b0);
    set_config(SIZE_8, 2'd3);
    run_xfer(1'b1, SIZE_32, $urandom(), 1'b0);
    run_xfer(1'b0, SIZE_16, '0, 1'b0);
    end_test("wait states");
  endtask

  task automatic test_busy_ignore();
    set_config(SIZE_8, 2'd1);
    run_xfer(1'b0, SIZE_32, '0, 1'b1);  // second valid lands mid transfer
    end_test("busy ignore");
  endtask

  initial
  begin
    int rst_cnt;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    host_req <= '0;
    void'($urandom(32'h683f));
    rst_cnt = 0;
    while (n_sys_reset2 !== 1'b1 && rst_cnt < 20)
    begin
      @(posedge sys_clk2);
      rst_cnt++;
    end
    if (n_sys_reset2 !== 1'b1)
    begin
      $display("timeout: reset was never released");
      $display("*** FAILED ***");
      $finish;
    end
    else
    begin
      test_regs();
      test_wide_writes();
      test_wide_reads();
      test_narrow_reads();
      test_wait_timing();
      test_busy_ignore();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
        $display("*** PASSED ***");
      else
        $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
rtl/mac_pkg.sv
rtl/mac_config_regs.sv
rtl/mac_access_seq.sv
rtl/mac_read_assemble.sv
rtl/mac_write_steer.sv
rtl/mac_top.sv
tests/tb_clock_gen.sv
tests/tb_mac_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mac testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_mac_top -o sim_mac
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_mac > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF '*** PASSED ***' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
